//--- source/mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W         = 32;
    localparam int BEAT_W         = 64;                       // one burst beat
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_W         = BEAT_W * BEATS_PER_LINE;  // 256 bit cacheline
    localparam int NUM_LINES      = 8;

    // address split for the direct-mapped cache
    localparam int OFFSET_W = $clog2(LINE_W / 8);             // byte offset in a line
    localparam int INDEX_W  = $clog2(NUM_LINES);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

endpackage

//--- source/fetch_pkg.sv
package fetch_pkg;

    localparam int          INST_W     = 32;
    localparam int          INST_BYTES = INST_W / 8;      // pc step
    localparam logic [31:0] RESET_PC   = 32'h1eceb000;

    localparam int FQ_DEPTH = 16;
    localparam int FQ_PTR_W = $clog2(FQ_DEPTH);

endpackage

//--- source/line_adapter.sv
`timescale 1ns/1ns

module line_adapter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [mem_pkg::BEAT_W-1:0]  bmem_rdata_i,
    input  logic                        bmem_rvalid_i,
    output logic [mem_pkg::LINE_W-1:0]  line_o,
    output logic                        line_valid_o
);
    import mem_pkg::*;

    logic [LINE_W-1:0]                  line_q;
    logic [$clog2(BEATS_PER_LINE)-1:0]  beat_cnt_q;
    logic                               line_valid_q;
    logic                               last_beat;

    assign last_beat    = bmem_rvalid_i && (beat_cnt_q == BEATS_PER_LINE - 1);
    assign line_o       = line_q;
    assign line_valid_o = line_valid_q;

    // lowest address arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_W-1:BEAT_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q   <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= last_beat;          // one cycle pulse
            if (bmem_rvalid_i) begin
                beat_cnt_q <= beat_cnt_q + 1'b1; // wraps to zero after the last beat
            end
        end
    end

    // only one line read is in flight, so no beat can follow the report
    no_beat_during_report: assert property (
        @(posedge clk) disable iff (rst)
        line_valid_o |-> !bmem_rvalid_i
    ) else $error("line_adapter: beat arrived while a line was reported");

endmodule

//--- source/icache.sv
`timescale 1ns/1ns

module icache (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_i,
    input  logic [mem_pkg::ADDR_W-1:0]    req_addr_i,
    output logic                          resp_o,
    output logic [fetch_pkg::INST_W-1:0]  resp_data_o,
    output logic [mem_pkg::ADDR_W-1:0]    bmem_addr_o,
    output logic                          bmem_read_o,
    input  logic                          bmem_ready_i,
    input  logic [mem_pkg::LINE_W-1:0]    line_i,
    input  logic                          line_valid_i
);
    import mem_pkg::*;
    import fetch_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_compare,
        s_request,
        s_wait,
        s_fill
    } state_t;

    state_t state_q;
    state_t state_d;

    logic [LINE_W-1:0]     data_q [NUM_LINES];
    logic [TAG_W-1:0]      tag_q  [NUM_LINES];
    logic [NUM_LINES-1:0]  valid_q;

    logic [ADDR_W-1:0]     addr_q;
    logic [TAG_W-1:0]      addr_tag;
    logic [INDEX_W-1:0]    addr_index;
    logic [OFFSET_W-3:0]   word_sel;
    logic                  hit;
    logic                  install;

    assign addr_tag   = addr_q[ADDR_W-1 -: TAG_W];
    assign addr_index = addr_q[OFFSET_W +: INDEX_W];
    assign word_sel   = addr_q[OFFSET_W-1:2];           // word within the line
    assign hit        = valid_q[addr_index] && (tag_q[addr_index] == addr_tag);
    assign install    = (state_q == s_wait) && line_valid_i;

    assign resp_data_o = data_q[addr_index][word_sel * INST_W +: INST_W];
    assign bmem_addr_o = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    always_comb begin
        state_d     = state_q;
        resp_o      = 1'b0;
        bmem_read_o = 1'b0;
        unique case (state_q)
            s_idle: begin
                if (req_i) begin
                    state_d = s_compare;
                end
            end
            s_compare: begin
                if (hit) begin
                    resp_o  = 1'b1;
                    state_d = s_idle;
                end else begin
                    bmem_read_o = 1'b1;             // miss raises the read at once
                    state_d     = bmem_ready_i ? s_wait : s_request;
                end
            end
            s_request: begin
                bmem_read_o = 1'b1;                 // hold until accepted
                if (bmem_ready_i) begin
                    state_d = s_wait;
                end
            end
            s_wait: begin
                if (line_valid_i) begin
                    state_d = s_fill;
                end
            end
            s_fill: begin
                resp_o  = 1'b1;                     // read back the installed line
                state_d = s_idle;
            end
            default: state_d = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= s_idle;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (install) begin
                valid_q[addr_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == s_idle && req_i) begin
            addr_q <= req_addr_i;
        end
        if (install) begin
            data_q[addr_index] <= line_i;
            tag_q[addr_index]  <= addr_tag;
        end
    end

    // the fetch unit waits for each response before asking again
    req_only_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        req_i |-> (state_q == s_idle)
    ) else $error("icache: request while a previous one is in progress");

endmodule

//--- source/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush_i,
    input  logic                          enq_i,
    input  logic [mem_pkg::ADDR_W-1:0]    enq_pc_i,
    input  logic [fetch_pkg::INST_W-1:0]  enq_inst_i,
    input  logic                          deq_i,
    output logic                          valid_o,
    output logic [mem_pkg::ADDR_W-1:0]    pc_o,
    output logic [fetch_pkg::INST_W-1:0]  inst_o,
    output logic                          full_o,
    output logic [fetch_pkg::FQ_PTR_W:0]  free_o
);
    import mem_pkg::*;
    import fetch_pkg::*;

    logic [ADDR_W-1:0]    pc_q   [FQ_DEPTH];
    logic [INST_W-1:0]    inst_q [FQ_DEPTH];

    logic [FQ_PTR_W-1:0]  wr_ptr_q;
    logic [FQ_PTR_W-1:0]  rd_ptr_q;
    logic [FQ_PTR_W:0]    count_q;

    assign valid_o = (count_q != '0);
    assign full_o  = (count_q == (FQ_PTR_W + 1)'(FQ_DEPTH));
    assign free_o  = (FQ_PTR_W + 1)'(FQ_DEPTH) - count_q;
    assign pc_o    = pc_q[rd_ptr_q];
    assign inst_o  = inst_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;    // pointers wrap with the depth
            end
            if (deq_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({enq_i, deq_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq_i) begin
            pc_q[wr_ptr_q]   <= enq_pc_i;
            inst_q[wr_ptr_q] <= enq_inst_i;
        end
    end

    no_enq_when_full: assert property (
        @(posedge clk) disable iff (rst)
        enq_i |-> !full_o
    ) else $error("fetch_queue: enqueue while full");

    no_deq_when_empty: assert property (
        @(posedge clk) disable iff (rst)
        deq_i |-> valid_o
    ) else $error("fetch_queue: dequeue while empty");

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect_i,
    input  logic [mem_pkg::ADDR_W-1:0]    redirect_pc_i,
    output logic                          req_o,
    output logic [mem_pkg::ADDR_W-1:0]    req_addr_o,
    input  logic                          resp_i,
    input  logic [fetch_pkg::INST_W-1:0]  resp_data_i,
    output logic                          enq_o,
    output logic [mem_pkg::ADDR_W-1:0]    enq_pc_o,
    output logic [fetch_pkg::INST_W-1:0]  enq_inst_o,
    output logic                          flush_o,
    input  logic [fetch_pkg::FQ_PTR_W:0]  free_i
);
    import mem_pkg::*;
    import fetch_pkg::*;

    logic [ADDR_W-1:0]  pc_q;
    logic [ADDR_W-1:0]  pend_pc_q;
    logic               req_q;
    logic               pending_q;
    logic               discard_q;
    logic               issue;
    logic               keep;

    // one request at a time, and room must stay for it in the queue
    assign issue = !pending_q && (free_i > (FQ_PTR_W + 1)'(1));
    assign keep  = resp_i && !discard_q && !redirect_i;

    assign req_o      = req_q;
    assign req_addr_o = pc_q;
    assign enq_o      = keep;
    assign enq_pc_o   = pend_pc_q;
    assign enq_inst_o = resp_data_i;
    assign flush_o    = redirect_i;     // queue drops everything on the same edge

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= RESET_PC;
            req_q     <= 1'b0;
            pending_q <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            req_q <= issue;
            if (issue) begin
                pending_q <= 1'b1;
            end else if (resp_i) begin
                pending_q <= 1'b0;
            end

            if (resp_i) begin
                discard_q <= 1'b0;
            end else if (redirect_i && pending_q) begin
                discard_q <= 1'b1;      // stale response still on its way
            end

            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (keep) begin
                pc_q <= pend_pc_q + ADDR_W'(INST_BYTES);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_q) begin
            pend_pc_q <= pc_q;
        end
    end

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic                          clk,
    input  logic                          rst,
    output logic [mem_pkg::ADDR_W-1:0]    bmem_addr_o,
    output logic                          bmem_read_o,
    input  logic                          bmem_ready_i,
    input  logic [mem_pkg::BEAT_W-1:0]    bmem_rdata_i,
    input  logic                          bmem_rvalid_i,
    input  logic                          redirect_i,
    input  logic [mem_pkg::ADDR_W-1:0]    redirect_pc_i,
    output logic                          inst_valid_o,
    output logic [fetch_pkg::INST_W-1:0]  inst_o,
    output logic [mem_pkg::ADDR_W-1:0]    inst_pc_o,
    input  logic                          inst_ready_i
);
    import mem_pkg::*;
    import fetch_pkg::*;

    logic                 req;
    logic [ADDR_W-1:0]    req_addr;
    logic                 resp;
    logic [INST_W-1:0]    resp_data;
    logic [LINE_W-1:0]    line;
    logic                 line_valid;
    logic                 enq;
    logic [ADDR_W-1:0]    enq_pc;
    logic [INST_W-1:0]    enq_inst;
    logic                 flush;
    logic [FQ_PTR_W:0]    free;
    logic                 deq;

    assign deq = inst_valid_o && inst_ready_i;

    fetch_unit fetch_unit_i (
        .clk(clk), .rst(rst),
        .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
        .req_o(req), .req_addr_o(req_addr),
        .resp_i(resp), .resp_data_i(resp_data),
        .enq_o(enq), .enq_pc_o(enq_pc), .enq_inst_o(enq_inst),
        .flush_o(flush), .free_i(free)
    );

    icache icache_i (
        .clk(clk), .rst(rst),
        .req_i(req), .req_addr_i(req_addr),
        .resp_o(resp), .resp_data_o(resp_data),
        .bmem_addr_o(bmem_addr_o), .bmem_read_o(bmem_read_o),
        .bmem_ready_i(bmem_ready_i),
        .line_i(line), .line_valid_i(line_valid)
    );

    line_adapter line_adapter_i (
        .clk(clk), .rst(rst),
        .bmem_rdata_i(bmem_rdata_i), .bmem_rvalid_i(bmem_rvalid_i),
        .line_o(line), .line_valid_o(line_valid)
    );

    fetch_queue fetch_queue_i (
        .clk(clk), .rst(rst),
        .flush_i(flush),
        .enq_i(enq), .enq_pc_i(enq_pc), .enq_inst_i(enq_inst),
        .deq_i(deq),
        .valid_o(inst_valid_o), .pc_o(inst_pc_o), .inst_o(inst_o),
        .full_o(),              // back-pressure goes through the free count
        .free_o(free)
    );

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;
    import mem_pkg::*;
    import fetch_pkg::*;

    localparam int NUM_TESTS   = 5;
    localparam int CYCLES_EACH = 2000;
    localparam int QUIET_TIME  = 60;       // longer than any gap between two misses

    logic               clk = 1'b0;
    logic               rst;
    logic [ADDR_W-1:0]  bmem_addr_o;
    logic               bmem_read_o;
    logic               bmem_ready_i;
    logic [BEAT_W-1:0]  bmem_rdata_i;
    logic               bmem_rvalid_i;
    logic               redirect_i;
    logic [ADDR_W-1:0]  redirect_pc_i;
    logic               inst_valid_o;
    logic [INST_W-1:0]  inst_o;
    logic [ADDR_W-1:0]  inst_pc_o;
    logic               inst_ready_i;

    logic [ADDR_W-1:0]  expected_pc;       // next pc the consumer should see
    logic [ADDR_W-1:0]  last_read_addr;
    int                 read_count;        // accepted line reads
    logic               mem_busy;

    always #10 clk = ~clk;

    fetch_top DUT (
        .clk(clk), .rst(rst),
        .bmem_addr_o(bmem_addr_o), .bmem_read_o(bmem_read_o),
        .bmem_ready_i(bmem_ready_i),
        .bmem_rdata_i(bmem_rdata_i), .bmem_rvalid_i(bmem_rvalid_i),
        .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
        .inst_valid_o(inst_valid_o), .inst_o(inst_o), .inst_pc_o(inst_pc_o),
        .inst_ready_i(inst_ready_i)
    );

    // every memory word is derived from its own byte address
    function automatic logic [INST_W-1:0] expected_inst(input logic [ADDR_W-1:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    task automatic check_inst(input string name, input logic [INST_W-1:0] expected,
                              input logic [INST_W-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected inst %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "instruction value is wrong");
        end
    endtask

    task automatic check_pc(input string name, input logic [ADDR_W-1:0] expected,
                            input logic [ADDR_W-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected pc %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "address is wrong");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Mismatch %s: expected read count %0d, actual %0d", name, expected,
                     actual);
            $display("TEST FAILED");
            $fatal(1, "memory read count is wrong");
        end
    endtask

    // takes count entries with ready high at the given percentage per cycle
    task automatic consume(input string name, input int count, input int ready_pct);
        int taken;
        taken = 0;
        while (taken < count) begin
            @(posedge clk);
            #2;
            inst_ready_i = ($urandom_range(99, 0) < ready_pct);
            if (inst_valid_o && inst_ready_i) begin
                check_pc(name, expected_pc, inst_pc_o);
                check_inst(name, expected_inst(expected_pc), inst_o);
                expected_pc = expected_pc + 32'd4;
                taken       = taken + 1;
            end
        end
        @(posedge clk);                     // last entry leaves on this edge
        #2;
        inst_ready_i = 1'b0;
    endtask

    task automatic redirect_to(input logic [ADDR_W-1:0] pc);
        @(posedge clk);
        #2;
        inst_ready_i  = 1'b0;
        redirect_i    = 1'b1;
        redirect_pc_i = pc;
        @(posedge clk);
        #2;
        redirect_i  = 1'b0;
        expected_pc = pc;
    endtask

    // fetch has stalled on a full queue once memory stays idle this long
    task automatic wait_quiet(input int cycles);
        int quiet;
        quiet = 0;
        while (quiet < cycles) begin
            @(posedge clk);
            #2;
            if (bmem_read_o || mem_busy) begin
                quiet = 0;
            end else begin
                quiet = quiet + 1;
            end
        end
    endtask

    initial begin : memory_model
        logic [ADDR_W-1:0] line_addr;
        logic [ADDR_W-1:0] beat_addr;
        int                delay;
        int                beat;
        bmem_ready_i   = 1'b0;
        bmem_rdata_i   = '0;
        bmem_rvalid_i  = 1'b0;
        read_count     = 0;
        last_read_addr = '0;
        mem_busy       = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (bmem_read_o && !rst) begin
                mem_busy  = 1'b1;
                line_addr = bmem_addr_o;
                delay     = $urandom_range(3, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                bmem_ready_i = 1'b1;
                @(posedge clk);             // accept edge
                #2;
                bmem_ready_i   = 1'b0;
                read_count     = read_count + 1;
                last_read_addr = line_addr;
                for (beat = 0; beat < BEATS_PER_LINE; beat++) begin
                    delay = $urandom_range(2, 0);
                    repeat (delay) begin
                        @(posedge clk);
                        #2;
                    end
                    beat_addr     = line_addr + ADDR_W'(beat * 8);
                    bmem_rdata_i  = {expected_inst(beat_addr + 32'd4), expected_inst(beat_addr)};
                    bmem_rvalid_i = 1'b1;
                    @(posedge clk);
                    #2;
                    bmem_rvalid_i = 1'b0;
                end
                mem_busy = 1'b0;
            end
        end
    end

    initial begin : main_sequence
        logic [ADDR_W-1:0] jump_pc;
        int                base_count;
        void'($urandom(91599));
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        inst_ready_i  = 1'b0;
        expected_pc   = RESET_PC;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        consume("sequential", 40, 100);
        consume("backpressure", 100, 50);

        jump_pc = $urandom() & 32'hffff_fffc;
        wait_quiet(QUIET_TIME);
        redirect_to(jump_pc);               // queue still holds older entries here
        consume("redirect", 24, 100);

        redirect_to(RESET_PC);
        consume("hit_warmup", 16, 100);
        wait_quiet(QUIET_TIME);
        base_count = read_count;
        redirect_to(RESET_PC);
        consume("cache_hit", 16, 100);
        check_count("cache_hit", base_count, read_count);

        // line 8 shares index 0 with the first line
        redirect_to(RESET_PC);
        consume("conflict_sweep", 9 * 8, 100);
        wait_quiet(QUIET_TIME);
        base_count = read_count;
        redirect_to(RESET_PC);
        consume("conflict_refill", 1, 100);
        check_count("conflict_refill", base_count + 1, read_count);
        check_pc("conflict_refill", RESET_PC, last_read_addr);
        consume("conflict_refill", 7, 100);

        $display("TEST OK");
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_TESTS * CYCLES_EACH) @(posedge clk);
        $display("TEST FAILED");
        $fatal(1, "run did not finish in time");
    end

endmodule

//--- filelist.f
source/mem_pkg.sv
source/fetch_pkg.sv
source/line_adapter.sv
source/icache.sv
source/fetch_queue.sv
source/fetch_unit.sv
source/fetch_top.sv
dv/fetch_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fetch_tb -f filelist.f -o fetch_sim \
    && ./obj_dir/fetch_sim \
    || exit 1
